// File: src/cluster_cfg_pkg.sv
package cluster_cfg_pkg;

  // ----------------------------------------
  // datapath widths
  // ----------------------------------------

  // operands, results and program counters
  localparam int unsigned XLEN = 32;

  // tag that follows each instruction from issue to writeback
  localparam int unsigned TRANS_ID_BITS = 3;

  // ----------------------------------------
  // decoded payload layout
  // ----------------------------------------

  // whole payload word as delivered by issue
  localparam int unsigned PAYLOAD_BITS = 16;

  // alu immediate, sign extended to XLEN
  localparam int unsigned IMM_BITS = 12;

  // branch offset in bytes, sign extended to XLEN
  localparam int unsigned OFFSET_BITS = 13;

  // ----------------------------------------
  // performance counters
  // ----------------------------------------

  // both counters wrap at this width
  localparam int unsigned PERF_CNT_BITS = 16;

endpackage

// File: src/cluster_types_pkg.sv
package cluster_types_pkg;

  import cluster_cfg_pkg::*;

  // ----------------------------------------
  // operation encodings
  // ----------------------------------------

  // owning functional unit
  typedef enum logic {
    ALU,
    BRANCH
  } fu_t;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SLT
  } alu_op_t;

  // codes 5 to 7 are unused
  typedef enum logic [2:0] {
    BEQ,
    BNE,
    BLT,
    BGE,
    JAL
  } branch_op_t;

  // operation field, meaning depends on fu
  typedef union packed {
    alu_op_t    alu;
    branch_op_t branch;
  } op_u;

  // ----------------------------------------
  // payload word
  // ----------------------------------------

  // alu view: immediate replaces operand_b when use_imm is set
  typedef struct packed {
    logic                       use_imm;
    logic [2:0]                 rsvd;
    logic signed [IMM_BITS-1:0] imm;
  } alu_payload_t;

  // branch view: front end prediction plus byte offset from pc
  typedef struct packed {
    logic                          pred_taken;
    logic [1:0]                    rsvd;
    logic signed [OFFSET_BITS-1:0] offset;
  } br_payload_t;

  typedef union packed {
    alu_payload_t alu;
    br_payload_t  branch;
  } payload_u;

  // ----------------------------------------
  // records between stages
  // ----------------------------------------

  typedef struct packed {
    logic                     valid;
    fu_t                      fu;
    op_u                      op;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    payload_u                 payload;
    logic [XLEN-1:0]          pc;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } issue_t;

  // one result per unit per cycle
  typedef struct packed {
    logic                     valid;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          result;
  } fu_result_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] target;
    logic            taken;
    logic            mispredict;
  } bp_resolve_t;

endpackage

// File: src/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  cluster_types_pkg::issue_t     issue_i,
  output cluster_types_pkg::fu_result_t alu_res_o
);

  import cluster_cfg_pkg::*;
  import cluster_types_pkg::*;

  logic                     alu_valid;
  logic [XLEN-1:0]          imm_sext;
  logic [XLEN-1:0]          operand_b;
  logic [4:0]               shamt;
  logic [XLEN-1:0]          result_d;

  logic                     valid_q;
  logic [TRANS_ID_BITS-1:0] trans_id_q;
  logic [XLEN-1:0]          result_q;

  // ----------------------------------------
  // operand selection
  // ----------------------------------------

  // only instructions steered to this unit
  assign alu_valid = issue_i.valid && (issue_i.fu == ALU);

  assign imm_sext = {{(XLEN-IMM_BITS){issue_i.payload.alu.imm[IMM_BITS-1]}},
                     issue_i.payload.alu.imm};

  assign operand_b = issue_i.payload.alu.use_imm ? imm_sext : issue_i.operand_b;

  // shift amount from the low bits of the second operand
  assign shamt = operand_b[4:0];

  // ----------------------------------------
  // compute
  // ----------------------------------------

  always_comb begin
    result_d = '0;
    case (issue_i.op.alu)
      ADD: result_d = issue_i.operand_a + operand_b;
      SUB: result_d = issue_i.operand_a - operand_b;
      AND: result_d = issue_i.operand_a & operand_b;
      OR:  result_d = issue_i.operand_a | operand_b;
      XOR: result_d = issue_i.operand_a ^ operand_b;
      SLL: result_d = issue_i.operand_a << shamt;
      SRL: result_d = issue_i.operand_a >> shamt;
      // signed compare, result is 0 or 1
      SLT: result_d = XLEN'($signed(issue_i.operand_a) < $signed(operand_b));
      default: result_d = '0;
    endcase
  end

  // ----------------------------------------
  // result register
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= alu_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_valid) begin
      trans_id_q <= issue_i.trans_id;
      result_q   <= result_d;
    end
  end

  assign alu_res_o = '{valid: valid_q, trans_id: trans_id_q, result: result_q};

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  cluster_types_pkg::issue_t      issue_i,
  output cluster_types_pkg::fu_result_t  br_res_o,
  output cluster_types_pkg::bp_resolve_t br_resolve_o
);

  import cluster_cfg_pkg::*;
  import cluster_types_pkg::*;

  logic                     br_valid;
  logic                     is_jal;
  logic [XLEN-1:0]          offset_sext;
  logic [XLEN-1:0]          target;
  logic [XLEN-1:0]          link;
  logic                     taken;
  logic                     mispredict;

  logic                     res_valid_q;
  logic                     resolve_valid_q;
  logic [TRANS_ID_BITS-1:0] trans_id_q;
  logic [XLEN-1:0]          link_q;
  logic [XLEN-1:0]          pc_q;
  logic [XLEN-1:0]          target_q;
  logic                     taken_q;
  logic                     mispredict_q;

  assign br_valid = issue_i.valid && (issue_i.fu == BRANCH);
  assign is_jal   = (issue_i.op.branch == JAL);

  // ----------------------------------------
  // condition
  // ----------------------------------------

  always_comb begin
    taken = 1'b0;
    case (issue_i.op.branch)
      BEQ: taken = (issue_i.operand_a == issue_i.operand_b);
      BNE: taken = (issue_i.operand_a != issue_i.operand_b);
      BLT: taken = ($signed(issue_i.operand_a) < $signed(issue_i.operand_b));
      BGE: taken = ($signed(issue_i.operand_a) >= $signed(issue_i.operand_b));
      JAL: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // ----------------------------------------
  // target and link
  // ----------------------------------------

  assign offset_sext = {{(XLEN-OFFSET_BITS){issue_i.payload.branch.offset[OFFSET_BITS-1]}},
                        issue_i.payload.branch.offset};

  assign target = issue_i.pc + offset_sext;

  // return address for jal
  assign link = issue_i.pc + XLEN'(4);

  // front end guessed the wrong direction
  assign mispredict = (taken != issue_i.payload.branch.pred_taken);

  // ----------------------------------------
  // output registers
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q     <= 1'b0;
      resolve_valid_q <= 1'b0;
    end else begin
      res_valid_q     <= br_valid && is_jal;
      resolve_valid_q <= br_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (br_valid) begin
      trans_id_q   <= issue_i.trans_id;
      link_q       <= link;
      pc_q         <= issue_i.pc;
      target_q     <= target;
      taken_q      <= taken;
      mispredict_q <= mispredict;
    end
  end

  // writeback only carries the jal link value
  assign br_res_o = '{valid: res_valid_q, trans_id: trans_id_q, result: link_q};

  assign br_resolve_o = '{valid:      resolve_valid_q,
                          pc:         pc_q,
                          target:     target_q,
                          taken:      taken_q,
                          mispredict: mispredict_q};

  // issue side must hand over halfword aligned offsets
  br_offset_even_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    br_valid |-> !issue_i.payload.branch.offset[0]
  ) else $error("odd branch offset issued");

endmodule

// File: src/commit_merge.sv
`timescale 1ns/1ps

module commit_merge (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  cluster_types_pkg::fu_result_t               alu_res_i,
  input  cluster_types_pkg::fu_result_t               br_res_i,
  input  cluster_types_pkg::bp_resolve_t              br_resolve_i,
  output cluster_types_pkg::fu_result_t               wb_o,
  output cluster_types_pkg::bp_resolve_t              resolved_branch_o,
  output logic                                        flush_o,
  output logic [cluster_cfg_pkg::PERF_CNT_BITS-1:0]   commit_cnt_o,
  output logic [cluster_cfg_pkg::PERF_CNT_BITS-1:0]   mispredict_cnt_o
);

  import cluster_cfg_pkg::*;
  import cluster_types_pkg::*;

  fu_result_t               sel_res;
  logic                     commit_inc;
  logic                     mispredict_inc;

  logic                     wb_valid_q;
  logic [TRANS_ID_BITS-1:0] wb_trans_id_q;
  logic [XLEN-1:0]          wb_result_q;

  logic                     rb_valid_q;
  logic [XLEN-1:0]          rb_pc_q;
  logic [XLEN-1:0]          rb_target_q;
  logic                     rb_taken_q;
  logic                     rb_mispredict_q;

  logic                     flush_q;
  logic [PERF_CNT_BITS-1:0] commit_cnt_q;
  logic [PERF_CNT_BITS-1:0] mispredict_cnt_q;

  // ----------------------------------------
  // merge
  // ----------------------------------------

  // at most one unit has a result in any cycle
  assign sel_res = br_res_i.valid ? br_res_i : alu_res_i;

  // jal has both a writeback and a resolution, count it once
  assign commit_inc     = alu_res_i.valid || br_resolve_i.valid;
  assign mispredict_inc = br_resolve_i.valid && br_resolve_i.mispredict;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_q       <= 1'b0;
      rb_valid_q       <= 1'b0;
      flush_q          <= 1'b0;
      commit_cnt_q     <= '0;
      mispredict_cnt_q <= '0;
    end else begin
      wb_valid_q <= sel_res.valid;
      rb_valid_q <= br_resolve_i.valid;
      flush_q    <= mispredict_inc;
      // counters wrap
      if (commit_inc) begin
        commit_cnt_q <= commit_cnt_q + 1'b1;
      end
      if (mispredict_inc) begin
        mispredict_cnt_q <= mispredict_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_res.valid) begin
      wb_trans_id_q <= sel_res.trans_id;
      wb_result_q   <= sel_res.result;
    end
    if (br_resolve_i.valid) begin
      rb_pc_q         <= br_resolve_i.pc;
      rb_target_q     <= br_resolve_i.target;
      rb_taken_q      <= br_resolve_i.taken;
      rb_mispredict_q <= br_resolve_i.mispredict;
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------

  assign wb_o = '{valid: wb_valid_q, trans_id: wb_trans_id_q, result: wb_result_q};

  assign resolved_branch_o = '{valid:      rb_valid_q,
                               pc:         rb_pc_q,
                               target:     rb_target_q,
                               taken:      rb_taken_q,
                               mispredict: rb_mispredict_q};

  assign flush_o          = flush_q;
  assign commit_cnt_o     = commit_cnt_q;
  assign mispredict_cnt_o = mispredict_cnt_q;

  // single issue means the two units never finish together
  single_result_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(alu_res_i.valid && br_res_i.valid)
  ) else $error("alu and branch results valid in the same cycle");

endmodule

// File: src/exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  cluster_types_pkg::issue_t                 issue_i,
  output cluster_types_pkg::fu_result_t             wb_o,
  output cluster_types_pkg::bp_resolve_t            resolved_branch_o,
  output logic                                      flush_o,
  output logic [cluster_cfg_pkg::PERF_CNT_BITS-1:0] commit_cnt_o,
  output logic [cluster_cfg_pkg::PERF_CNT_BITS-1:0] mispredict_cnt_o
);

  import cluster_types_pkg::*;

  // unit results towards commit
  fu_result_t  alu_res;
  fu_result_t  br_res;
  bp_resolve_t br_resolve;

  // ----------------------------------------
  // fixed latency units
  // ----------------------------------------

  alu_unit i_alu_unit (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .issue_i   ( issue_i ),
    .alu_res_o ( alu_res )
  );

  branch_unit i_branch_unit (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .issue_i      ( issue_i    ),
    .br_res_o     ( br_res     ),
    .br_resolve_o ( br_resolve )
  );

  // ----------------------------------------
  // commit
  // ----------------------------------------

  commit_merge i_commit_merge (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .alu_res_i         ( alu_res           ),
    .br_res_i          ( br_res            ),
    .br_resolve_i      ( br_resolve        ),
    .wb_o              ( wb_o              ),
    .resolved_branch_o ( resolved_branch_o ),
    .flush_o           ( flush_o           ),
    .commit_cnt_o      ( commit_cnt_o      ),
    .mispredict_cnt_o  ( mispredict_cnt_o  )
  );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held low over the first two rising edges
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

// File: test/tb_exec_cluster.sv
`timescale 1ns/1ps

module tb_exec_cluster;

  import cluster_cfg_pkg::*;
  import cluster_types_pkg::*;

  // one stimulus row with its expected outcome
  typedef struct packed {
    fu_t                     fu;
    logic [2:0]              op;
    logic [XLEN-1:0]         a;
    logic [XLEN-1:0]         b;
    logic [PAYLOAD_BITS-1:0] payload;
    logic [XLEN-1:0]         pc;
    logic                    wb_valid;
    logic [XLEN-1:0]         wb_value;
    logic                    taken;
    logic [XLEN-1:0]         target;
    logic                    mispredict;
  } row_t;

  logic                     clk;
  logic                     rst_n;
  issue_t                   issue;
  fu_result_t               wb;
  bp_resolve_t              rb;
  logic                     flush;
  logic [PERF_CNT_BITS-1:0] commit_cnt;
  logic [PERF_CNT_BITS-1:0] mispredict_cnt;

  row_t table_q[$];
  int   errors;
  int   test_errors;
  int   passed;
  int   failed;
  int   seed_draw;

  tb_clock_gen u_clock_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  exec_cluster dut_i (
    .clk_i             ( clk            ),
    .rst_ni            ( rst_n          ),
    .issue_i           ( issue          ),
    .wb_o              ( wb             ),
    .resolved_branch_o ( rb             ),
    .flush_o           ( flush          ),
    .commit_cnt_o      ( commit_cnt     ),
    .mispredict_cnt_o  ( mispredict_cnt )
  );

  // ----------------------------------------
  // reference rules
  // ----------------------------------------

  // signed less-than from the sign bits
  function automatic logic less_signed(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    if (a[XLEN-1] != b[XLEN-1]) begin
      return a[XLEN-1];
    end
    return a < b;
  endfunction

  function automatic logic [XLEN-1:0] alu_expect(input logic [2:0] op,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    case (op)
      ADD:     return a + b;
      SUB:     return a + ~b + XLEN'(1);
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      default: return XLEN'(less_signed(a, b));
    endcase
  endfunction

  task automatic add_alu(input alu_op_t op, input logic use_imm, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic [IMM_BITS-1:0] imm);
    row_t            r;
    logic [XLEN-1:0] opb;
    r = '0;
    r.fu = ALU;
    r.op = op;
    r.a = a;
    r.b = b;
    r.payload = {use_imm, 3'b000, imm};
    r.pc = 32'h0000_1000 + (XLEN'(table_q.size()) << 2);
    opb = use_imm ? {{(XLEN-IMM_BITS){imm[IMM_BITS-1]}}, imm} : b;
    r.wb_valid = 1'b1;
    r.wb_value = alu_expect(op, a, opb);
    table_q.push_back(r);
  endtask

  task automatic add_branch(input branch_op_t op, input logic pred, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input logic [OFFSET_BITS-1:0] offset);
    row_t r;
    r = '0;
    r.fu = BRANCH;
    r.op = op;
    r.a = a;
    r.b = b;
    r.payload = {pred, 2'b00, offset};
    r.pc = 32'h0000_1000 + (XLEN'(table_q.size()) << 2);
    case (op)
      BEQ:     r.taken = (a == b);
      BNE:     r.taken = (a != b);
      BLT:     r.taken = less_signed(a, b);
      BGE:     r.taken = !less_signed(a, b);
      default: r.taken = 1'b1;
    endcase
    r.target = r.pc + {{(XLEN-OFFSET_BITS){offset[OFFSET_BITS-1]}}, offset};
    r.mispredict = (r.taken != pred);
    // only jal writes back, with its return address
    r.wb_valid = (op == JAL);
    r.wb_value = r.pc + XLEN'(4);
    table_q.push_back(r);
  endtask

  task automatic build_table();
    int k;
    for (k = 0; k < 8; k++) begin
      add_alu(alu_op_t'(k), 1'b0, 32'hF0F0_1234, 32'h0000_0013, '0);
    end
    add_alu(SLT, 1'b0, 32'h0000_0001, 32'hFFFF_FFFE, '0);
    // immediate form with random operand and immediate
    for (k = 0; k < 8; k++) begin
      add_alu(alu_op_t'(k), 1'b1, $urandom, $urandom, IMM_BITS'($urandom));
    end
    add_branch(BEQ, 1'b1, 32'h55, 32'h55, 13'h0010);
    add_branch(BEQ, 1'b1, 32'h55, 32'h56, 13'h0010);
    add_branch(BNE, 1'b1, 32'h01, 32'h02, 13'h0ffe);
    add_branch(BLT, 1'b0, 32'hFFFF_FFFD, 32'h02, 13'h1ff0);
    add_branch(BGE, 1'b1, 32'h02, 32'hFFFF_FFFD, 13'h0020);
    add_branch(BGE, 1'b0, 32'h77, 32'h77, 13'h1000);
    add_branch(JAL, 1'b0, '0, '0, 13'h0100);
    add_branch(JAL, 1'b1, '0, '0, 13'h1ffc);
    for (k = 0; k < 4; k++) begin
      add_branch(branch_op_t'(3'($urandom % 4)), 1'($urandom), $urandom, $urandom,
                 OFFSET_BITS'($urandom) << 1);
    end
  endtask

  // ----------------------------------------
  // checking and report
  // ----------------------------------------

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp,
                                 input logic [XLEN-1:0] act);
    $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
    errors++;
    test_errors++;
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      passed++;
      $display("%s passed", name);
    end else begin
      failed++;
      $display("%s failed with %0d mismatches", name, test_errors);
    end
  endtask

  task automatic drive_row(input int i);
    issue = '0;
    issue.valid = 1'b1;
    issue.fu = table_q[i].fu;
    issue.op = table_q[i].op;
    issue.operand_a = table_q[i].a;
    issue.operand_b = table_q[i].b;
    issue.payload = table_q[i].payload;
    issue.pc = table_q[i].pc;
    issue.trans_id = TRANS_ID_BITS'(i);
  endtask

  task automatic check_row(input int i);
    row_t r;
    r = table_q[i];
    test_errors = 0;
    if (wb.valid !== r.wb_valid) report_mismatch("wb_o.valid", r.wb_valid, wb.valid);
    if (r.wb_valid) begin
      if (wb.trans_id !== TRANS_ID_BITS'(i)) begin
        report_mismatch("wb_o.trans_id", i % 8, wb.trans_id);
      end
      if (wb.result !== r.wb_value) report_mismatch("wb_o.result", r.wb_value, wb.result);
    end
    if (rb.valid !== (r.fu == BRANCH)) begin
      report_mismatch("resolved_branch_o.valid", r.fu == BRANCH, rb.valid);
    end
    if (r.fu == BRANCH) begin
      if (rb.pc !== r.pc) report_mismatch("resolved_branch_o.pc", r.pc, rb.pc);
      if (rb.target !== r.target) report_mismatch("resolved_branch_o.target", r.target, rb.target);
      if (rb.taken !== r.taken) report_mismatch("resolved_branch_o.taken", r.taken, rb.taken);
      if (rb.mispredict !== r.mispredict) begin
        report_mismatch("resolved_branch_o.mispredict", r.mispredict, rb.mispredict);
      end
    end
    if (flush !== (r.fu == BRANCH && r.mispredict)) begin
      report_mismatch("flush_o", r.fu == BRANCH && r.mispredict, flush);
    end
    end_test($sformatf("row %0d %s op %0d", i, (r.fu == ALU) ? "alu" : "branch", r.op));
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    int wait_cycles;
    int idx;
    int n_mispredict;
    seed_draw = $urandom(32'h366fc179);
    errors = 0;
    passed = 0;
    failed = 0;
    issue = '0;
    build_table();
    wait_cycles = 0;
    while (rst_n !== 1'b1 && wait_cycles < 20) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout: reset was not released within 20 cycles");
      $display("Errors found");
      $finish;
    end else begin
      @(posedge clk);
      #1;
      test_errors = 0;
      if (wb.valid !== 1'b0) report_mismatch("wb_o.valid", 0, wb.valid);
      if (rb.valid !== 1'b0) report_mismatch("resolved_branch_o.valid", 0, rb.valid);
      if (flush !== 1'b0) report_mismatch("flush_o", 0, flush);
      if (commit_cnt !== '0) report_mismatch("commit_cnt_o", 0, commit_cnt);
      if (mispredict_cnt !== '0) report_mismatch("mispredict_cnt_o", 0, mispredict_cnt);
      end_test("reset state");
      // back to back issue, each row checked two edges after it is sampled
      for (idx = 0; idx < table_q.size() + 2; idx++) begin
        @(posedge clk);
        #1;
        if (idx >= 2) check_row(idx - 2);
        if (idx < table_q.size()) begin
          drive_row(idx);
        end else begin
          issue = '0;
        end
      end
      n_mispredict = 0;
      foreach (table_q[k]) begin
        if (table_q[k].fu == BRANCH && table_q[k].mispredict) n_mispredict++;
      end
      test_errors = 0;
      if (commit_cnt !== PERF_CNT_BITS'(table_q.size())) begin
        report_mismatch("commit_cnt_o", table_q.size(), commit_cnt);
      end
      if (mispredict_cnt !== PERF_CNT_BITS'(n_mispredict)) begin
        report_mismatch("mispredict_cnt_o", n_mispredict, mispredict_cnt);
      end
      end_test("performance counters");
      $display("tests passed %0d, tests failed %0d, mismatches %0d", passed, failed, errors);
      if (errors == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

endmodule

// File: list.f
src/cluster_cfg_pkg.sv
src/cluster_types_pkg.sv
src/alu_unit.sv
src/branch_unit.sv
src/commit_merge.sv
src/exec_cluster.sv
test/tb_clock_gen.sv
test/tb_exec_cluster.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_exec_cluster
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "No errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
